// File: rtl/isa_pkg.sv
/*
 * Instruction word layout for the strand-select stage.
 * The class sits in the top four bits; only C_STRIDED uses the stride
 * immediate, which is read unsigned.
 * Latencies are issue-to-writeback cycle counts. Everything that is not
 * C_FPU counts as short latency.
 */
package isa_pkg;

	localparam int INSTR_WIDTH = 32;
	localparam int CLASS_WIDTH = 4;
	localparam int CLASS_LSB = INSTR_WIDTH - CLASS_WIDTH;
	localparam int STRIDE_LSB = 0;
	localparam int STRIDE_WIDTH = 8;

	localparam int SHORT_LATENCY = 1;
	localparam int LONG_LATENCY = 4;
	// A short issue this many cycles after a long one lands on the same writeback cycle
	localparam int WB_HAZARD_DISTANCE = LONG_LATENCY - SHORT_LATENCY;

	typedef logic [INSTR_WIDTH-1:0] instr_t;

	typedef enum logic [CLASS_WIDTH-1:0] {
		C_ALU     = 4'h0,
		C_FPU     = 4'h1,
		C_STRIDED = 4'h2,
		C_GATHER  = 4'h3,
		C_OTHER   = 4'hf
	} instr_class_t;

	localparam instr_t NOP = {C_OTHER, {CLASS_LSB{1'b0}}};

	function automatic instr_class_t class_of(instr_t instr);
		return instr_class_t'(instr[CLASS_LSB +: CLASS_WIDTH]);
	endfunction

	function automatic logic [STRIDE_WIDTH-1:0] stride_of(instr_t instr);
		return instr[STRIDE_LSB +: STRIDE_WIDTH];
	endfunction

	function automatic logic is_long_latency(instr_t instr);
		return class_of(instr) == C_FPU;
	endfunction

	// Vector memory ops issue once per lane
	function automatic logic is_multi_lane(instr_t instr);
		return (class_of(instr) == C_STRIDED) || (class_of(instr) == C_GATHER);
	endfunction

endpackage

// File: rtl/strand_pkg.sv
/*
 * Strand-level types for a four-strand barrel pipeline.
 * Masks carry one bit per strand, with bit n belonging to strand n.
 * Vector instructions run over NUM_LANES lanes, highest lane first.
 */
package strand_pkg;

	localparam int NUM_STRANDS = 4;
	localparam int NUM_LANES = 16;

	typedef logic [$clog2(NUM_STRANDS)-1:0] strand_idx_t;
	typedef logic [NUM_STRANDS-1:0] strand_mask_t;
	typedef logic [$clog2(NUM_LANES)-1:0] lane_t;
	typedef logic [31:0] offset_t;
	typedef logic [31:0] pc_t;

	typedef enum logic [1:0] {
		S_WAIT_INSTR,
		S_READY,
		S_SUSPENDED
	} fsm_state_t;

endpackage

// File: rtl/strand_fsm.sv
/*
 * Issue state machine for one strand.
 * instruction_i must stay stable from instruction_valid_i until the grant
 * that pulses next_instruction_o. Fetch keeps valid low for at least one
 * cycle after that pulse.
 * Rollback beats retry, and retry beats a grant in the same cycle.
 * The lane and offset restart at 15 and 0 once an instruction completes.
 */
module strand_fsm (
	input  logic                  clk,
	input  logic                  rst_i,
	input  isa_pkg::instr_t       instruction_i,
	input  logic                  instruction_valid_i,
	input  logic                  grant_i,
	input  logic                  rollback_i,
	input  logic                  retry_i,
	input  logic                  suspend_i,
	input  logic                  resume_i,
	input  strand_pkg::lane_t     rollback_lane_i,
	input  strand_pkg::offset_t   rollback_offset_i,
	output logic                  issue_request_o,
	output logic                  next_instruction_o,
	output strand_pkg::lane_t     lane_o,
	output strand_pkg::offset_t   offset_o
);

	strand_pkg::fsm_state_t state_q;
	strand_pkg::lane_t lane_q;
	strand_pkg::offset_t offset_q;
	logic multi_lane;
	logic granted;
	logic last_grant;
	strand_pkg::offset_t stride;

	assign multi_lane = isa_pkg::is_multi_lane(instruction_i);
	assign stride = strand_pkg::offset_t'(isa_pkg::stride_of(instruction_i));
	assign granted = grant_i && (state_q == strand_pkg::S_READY);

	// A single-lane instruction finishes on its only grant, a vector one on lane 0
	assign last_grant = granted && (!multi_lane || (lane_q == '0));

	assign issue_request_o = (state_q == strand_pkg::S_READY);
	assign next_instruction_o = rollback_i || (last_grant && !retry_i);
	assign lane_o = lane_q;
	assign offset_o = offset_q;

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			state_q <= strand_pkg::S_WAIT_INSTR;
			lane_q <= strand_pkg::lane_t'(strand_pkg::NUM_LANES - 1);
			offset_q <= '0;
		end
		else if (rollback_i)
		begin
			// Drop the instruction and resume at the faulting lane once refetched
			state_q <= strand_pkg::S_WAIT_INSTR;
			lane_q <= rollback_lane_i;
			offset_q <= rollback_offset_i;
		end
		else if (retry_i)
		begin
			state_q <= strand_pkg::S_READY;
		end
		else
		begin
			if (last_grant)
			begin
				lane_q <= strand_pkg::lane_t'(strand_pkg::NUM_LANES - 1);
				offset_q <= '0;
			end
			else if (granted)
			begin
				lane_q <= lane_q - 1'b1;
				if (isa_pkg::class_of(instruction_i) == isa_pkg::C_STRIDED)
					offset_q <= offset_q + stride;
			end

			if (suspend_i)
				state_q <= strand_pkg::S_SUSPENDED;
			else
			begin
				case (state_q)
					strand_pkg::S_WAIT_INSTR:
					begin
						if (instruction_valid_i)
							state_q <= strand_pkg::S_READY;
					end

					strand_pkg::S_READY:
					begin
						if (last_grant)
							state_q <= strand_pkg::S_WAIT_INSTR;
					end

					strand_pkg::S_SUSPENDED:
					begin
						if (resume_i)
							state_q <= strand_pkg::S_READY;
					end

					default:
						state_q <= strand_pkg::S_WAIT_INSTR;
				endcase
			end
		end
	end

endmodule

// File: rtl/execute_hazard_detect.sv
/*
 * Writeback collision check between long and short latency instructions.
 * Records one bit per cycle telling whether the granted instruction was
 * long latency. A strand holding a short instruction is blocked in the one
 * cycle where its writeback would coincide with that long one.
 * Long instructions never block each other since they share one latency.
 */
module execute_hazard_detect (
	input  logic                     clk,
	input  logic                     rst_i,
	input  isa_pkg::instr_t          instruction_i [strand_pkg::NUM_STRANDS],
	input  strand_pkg::strand_mask_t grant_i,
	output strand_pkg::strand_mask_t hazard_o
);

	localparam int DEPTH = isa_pkg::WB_HAZARD_DISTANCE;

	logic [DEPTH-1:0] long_history_q;
	strand_pkg::strand_mask_t long_mask;
	logic long_granted;

	always_comb
	begin
		for (int s = 0; s < strand_pkg::NUM_STRANDS; s++)
			long_mask[s] = isa_pkg::is_long_latency(instruction_i[s]);
	end

	assign long_granted = |(grant_i & long_mask);

	// Oldest bit marks a long grant exactly DEPTH cycles back
	always_ff @(posedge clk)
	begin
		if (rst_i)
			long_history_q <= '0;
		else
			long_history_q <= {long_history_q[DEPTH-2:0], long_granted};
	end

	always_comb
	begin
		for (int s = 0; s < strand_pkg::NUM_STRANDS; s++)
			hazard_o[s] = long_history_q[DEPTH-1] && !long_mask[s];
	end

endmodule

// File: rtl/issue_arbiter.sv
/*
 * Round-robin arbiter over the strands.
 * The search starts at the strand after the last winner and wraps around,
 * so the least recently granted requester wins.
 * The grant is combinational; the pointer moves at the end of a granting
 * cycle and holds while nothing is requested.
 */
module issue_arbiter (
	input  logic                     clk,
	input  logic                     rst_i,
	input  strand_pkg::strand_mask_t request_i,
	output strand_pkg::strand_mask_t grant_oh_o
);

	strand_pkg::strand_idx_t prio_q;
	strand_pkg::strand_idx_t winner;
	logic found;

	always_comb
	begin
		strand_pkg::strand_idx_t cand;

		grant_oh_o = '0;
		winner = prio_q;
		found = 1'b0;
		for (int k = 0; k < strand_pkg::NUM_STRANDS; k++)
		begin
			// Index arithmetic wraps at the strand count
			cand = prio_q + strand_pkg::strand_idx_t'(k);
			if (!found && request_i[cand])
			begin
				found = 1'b1;
				winner = cand;
				grant_oh_o[cand] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
			prio_q <= '0;
		else if (found)
			prio_q <= winner + 1'b1;
	end

endmodule

// File: rtl/strand_select_stage.sv
/*
 * Strand-select stage: picks one ready strand per cycle for decode.
 * A strand eligible in cycle N shows up on the ss_ outputs after the edge
 * ending cycle N. No back-pressure from decode is supported.
 * With no grant a NOP with PC 0 goes out, and strand, lane and offset
 * keep their last values.
 */
module strand_select_stage (
	input  logic                     clk,
	input  logic                     rst_i,
	input  strand_pkg::strand_mask_t strand_enable_i,
	input  isa_pkg::instr_t          instruction_i [strand_pkg::NUM_STRANDS],
	input  logic                     instruction_valid_i [strand_pkg::NUM_STRANDS],
	input  strand_pkg::pc_t          pc_i [strand_pkg::NUM_STRANDS],
	input  logic                     branch_predicted_i [strand_pkg::NUM_STRANDS],
	input  logic                     rollback_i [strand_pkg::NUM_STRANDS],
	input  logic                     retry_i [strand_pkg::NUM_STRANDS],
	input  logic                     suspend_i [strand_pkg::NUM_STRANDS],
	input  logic                     resume_i [strand_pkg::NUM_STRANDS],
	input  strand_pkg::lane_t        rollback_lane_i [strand_pkg::NUM_STRANDS],
	input  strand_pkg::offset_t      rollback_offset_i [strand_pkg::NUM_STRANDS],
	output strand_pkg::strand_mask_t next_instruction_o,
	output isa_pkg::instr_t          ss_instruction_o,
	output strand_pkg::pc_t          ss_pc_o,
	output logic                     ss_branch_predicted_o,
	output strand_pkg::strand_idx_t  ss_strand_o,
	output strand_pkg::lane_t        ss_lane_o,
	output strand_pkg::offset_t      ss_offset_o
);

	strand_pkg::strand_mask_t fsm_request;
	strand_pkg::strand_mask_t hazard;
	strand_pkg::strand_mask_t arb_request;
	strand_pkg::strand_mask_t grant_oh;
	strand_pkg::strand_idx_t grant_idx;
	strand_pkg::lane_t lane [strand_pkg::NUM_STRANDS];
	strand_pkg::offset_t offset [strand_pkg::NUM_STRANDS];

	for (genvar s = 0; s < strand_pkg::NUM_STRANDS; s++)
	begin : g_strand
		strand_fsm u_fsm (
			.clk                (clk),
			.rst_i              (rst_i),
			.instruction_i      (instruction_i[s]),
			.instruction_valid_i(instruction_valid_i[s]),
			.grant_i            (grant_oh[s]),
			.rollback_i         (rollback_i[s]),
			.retry_i            (retry_i[s]),
			.suspend_i          (suspend_i[s]),
			.resume_i           (resume_i[s]),
			.rollback_lane_i    (rollback_lane_i[s]),
			.rollback_offset_i  (rollback_offset_i[s]),
			.issue_request_o    (fsm_request[s]),
			.next_instruction_o (next_instruction_o[s]),
			.lane_o             (lane[s]),
			.offset_o           (offset[s])
		);
	end

	execute_hazard_detect u_hazard (
		.clk          (clk),
		.rst_i        (rst_i),
		.instruction_i(instruction_i),
		.grant_i      (grant_oh),
		.hazard_o     (hazard)
	);

	// Disabled strands and strands that would collide at writeback sit out
	assign arb_request = fsm_request & strand_enable_i & ~hazard;

	issue_arbiter u_arbiter (
		.clk       (clk),
		.rst_i     (rst_i),
		.request_i (arb_request),
		.grant_oh_o(grant_oh)
	);

	always_comb
	begin
		grant_idx = '0;
		for (int s = 0; s < strand_pkg::NUM_STRANDS; s++)
		begin
			if (grant_oh[s])
				grant_idx = strand_pkg::strand_idx_t'(s);
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			ss_instruction_o <= isa_pkg::NOP;
			ss_pc_o <= '0;
			ss_branch_predicted_o <= 1'b0;
			ss_strand_o <= '0;
			ss_lane_o <= '0;
			ss_offset_o <= '0;
		end
		else if (|grant_oh)
		begin
			ss_instruction_o <= instruction_i[grant_idx];
			ss_pc_o <= pc_i[grant_idx];
			ss_branch_predicted_o <= branch_predicted_i[grant_idx];
			ss_strand_o <= grant_idx;
			ss_lane_o <= lane[grant_idx];
			ss_offset_o <= offset[grant_idx];
		end
		else
		begin
			// Nothing eligible, so a bubble goes down the pipe
			ss_instruction_o <= isa_pkg::NOP;
			ss_pc_o <= '0;
			ss_branch_predicted_o <= 1'b0;
		end
	end

endmodule

// File: tb/tb_strand_select.sv
/*
 * Table-driven testbench for the strand-select stage.
 * Each row resets the DUT, loads one instruction per strand and runs a
 * fixed number of cycles. A cycle model in this file predicts the issue order.
 * Inputs change on the rising edge and outputs are sampled on the falling edge.
 */
module tb_strand_select;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NS = strand_pkg::NUM_STRANDS;
	localparam int HAZ_DIST = isa_pkg::LONG_LATENCY - isa_pkg::SHORT_LATENCY;
	localparam int NUM_ROWS = 9;
	localparam int MAX_LEN = 28;
	localparam int EV_NONE = 0;
	localparam int EV_SUSPEND = 1;
	localparam int EV_ROLLBACK = 2;
	localparam int EV_RETRY = 3;
	localparam int ST_WAIT = 0;
	localparam int ST_READY = 1;
	localparam int ST_SUSP = 2;

	logic clk;
	logic rst_i;
	strand_pkg::strand_mask_t en;
	isa_pkg::instr_t instr [NS];
	logic valid [NS];
	strand_pkg::pc_t pc [NS];
	logic bp [NS];
	logic rb [NS];
	logic rt [NS];
	logic susp [NS];
	logic res [NS];
	strand_pkg::lane_t rbl [NS];
	strand_pkg::offset_t rbo [NS];
	strand_pkg::strand_mask_t next_instruction_o;
	isa_pkg::instr_t ss_instruction_o;
	strand_pkg::pc_t ss_pc_o;
	logic ss_branch_predicted_o;
	strand_pkg::strand_idx_t ss_strand_o;
	strand_pkg::lane_t ss_lane_o;
	strand_pkg::offset_t ss_offset_o;

	// Test table, one entry per row in each array
	string row_name [NUM_ROWS];
	strand_pkg::strand_mask_t row_en [NUM_ROWS];
	strand_pkg::strand_mask_t row_load [NUM_ROWS];
	isa_pkg::instr_t row_instr [NUM_ROWS][NS];
	int row_len [NUM_ROWS];
	int row_kind [NUM_ROWS];
	int row_ev_s [NUM_ROWS];
	int row_ev_c [NUM_ROWS];
	int row_ev_c2 [NUM_ROWS];
	strand_pkg::lane_t row_rb_lane [NUM_ROWS];
	strand_pkg::offset_t row_rb_off [NUM_ROWS];
	int n_rows;

	// Reference model state
	int m_st [NS];
	strand_pkg::lane_t m_lane [NS];
	strand_pkg::offset_t m_off [NS];
	logic pend [NS];
	logic [HAZ_DIST-1:0] m_hist;
	strand_pkg::strand_idx_t m_ptr;
	isa_pkg::instr_t e_instr;
	strand_pkg::pc_t e_pc;
	logic e_bp;
	strand_pkg::strand_idx_t e_strand;
	strand_pkg::lane_t e_lane;
	strand_pkg::offset_t e_off;

	int errors;
	int row_errors;
	int failed_rows;
	int seed;

	strand_select_stage u_dut (
		.clk                  (clk),
		.rst_i                (rst_i),
		.strand_enable_i      (en),
		.instruction_i        (instr),
		.instruction_valid_i  (valid),
		.pc_i                 (pc),
		.branch_predicted_i   (bp),
		.rollback_i           (rb),
		.retry_i              (rt),
		.suspend_i            (susp),
		.resume_i             (res),
		.rollback_lane_i      (rbl),
		.rollback_offset_i    (rbo),
		.next_instruction_o   (next_instruction_o),
		.ss_instruction_o     (ss_instruction_o),
		.ss_pc_o              (ss_pc_o),
		.ss_branch_predicted_o(ss_branch_predicted_o),
		.ss_strand_o          (ss_strand_o),
		.ss_lane_o            (ss_lane_o),
		.ss_offset_o          (ss_offset_o)
	);

	always #4 clk = ~clk;

	function automatic isa_pkg::instr_t make_instr(isa_pkg::instr_class_t cls,
			logic [7:0] stride);
		return {cls, 20'h0, stride};
	endfunction

	function automatic logic [3:0] class_bits(isa_pkg::instr_t i);
		return i[isa_pkg::CLASS_LSB +: 4];
	endfunction

	function automatic logic long_class(isa_pkg::instr_t i);
		return class_bits(i) == 4'h1;
	endfunction

	function automatic logic vector_class(isa_pkg::instr_t i);
		return (class_bits(i) == 4'h2) || (class_bits(i) == 4'h3);
	endfunction

	task automatic note_error();
		errors++;
		row_errors++;
	endtask

	task automatic check_instr(string name, isa_pkg::instr_t got, isa_pkg::instr_t exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			note_error();
		end
	endtask

	task automatic check_pc(string name, strand_pkg::pc_t got, strand_pkg::pc_t exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			note_error();
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			note_error();
		end
	endtask

	task automatic check_strand(string name, strand_pkg::strand_idx_t got,
			strand_pkg::strand_idx_t exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			note_error();
		end
	endtask

	task automatic check_mask(string name, strand_pkg::strand_mask_t got,
			strand_pkg::strand_mask_t exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			note_error();
		end
	endtask

	task automatic check_lane_offset(strand_pkg::lane_t got_lane, strand_pkg::lane_t exp_lane,
			strand_pkg::offset_t got_off, strand_pkg::offset_t exp_off);
		if (got_lane !== exp_lane)
		begin
			$display("mismatch ss_lane_o: got %h expected %h", got_lane, exp_lane);
			note_error();
		end
		if (got_off !== exp_off)
		begin
			$display("mismatch ss_offset_o: got %h expected %h", got_off, exp_off);
			note_error();
		end
	endtask

	task automatic add_row(string name, strand_pkg::strand_mask_t e,
			strand_pkg::strand_mask_t ld,
			isa_pkg::instr_t i0, isa_pkg::instr_t i1, isa_pkg::instr_t i2, isa_pkg::instr_t i3,
			int len, int kind, int ev_s, int ev_c, int ev_c2,
			strand_pkg::lane_t rb_lane, strand_pkg::offset_t rb_off);
		row_name[n_rows] = name;
		row_en[n_rows] = e;
		row_load[n_rows] = ld;
		row_instr[n_rows][0] = i0;
		row_instr[n_rows][1] = i1;
		row_instr[n_rows][2] = i2;
		row_instr[n_rows][3] = i3;
		row_len[n_rows] = len;
		row_kind[n_rows] = kind;
		row_ev_s[n_rows] = ev_s;
		row_ev_c[n_rows] = ev_c;
		row_ev_c2[n_rows] = ev_c2;
		row_rb_lane[n_rows] = rb_lane;
		row_rb_off[n_rows] = rb_off;
		n_rows++;
	endtask

	task automatic build_table();
		isa_pkg::instr_t alu;
		isa_pkg::instr_t fpu;
		isa_pkg::instr_t gat;
		isa_pkg::instr_t alu_id [NS];

		alu = make_instr(isa_pkg::C_ALU, 8'h00);
		fpu = make_instr(isa_pkg::C_FPU, 8'h00);
		gat = make_instr(isa_pkg::C_GATHER, 8'h00);
		// ALU words that differ per strand, so a wrong strand shows up in the word
		for (int s = 0; s < NS; s++)
			alu_id[s] = make_instr(isa_pkg::C_ALU, 8'(8'h10 + s));
		n_rows = 0;
		add_row("round robin", 4'hf, 4'hf, alu_id[0], alu_id[1], alu_id[2], alu_id[3],
			8, EV_NONE, 0, 0, 0, '0, '0);
		add_row("enable mask", 4'h5, 4'hf, alu, alu, alu, alu, 8, EV_NONE, 0, 0, 0, '0, '0);
		add_row("all disabled", 4'h0, 4'hf, alu, alu, alu, alu, 6, EV_NONE, 0, 0, 0, '0, '0);
		add_row("strided vector", 4'hf, 4'h2, alu, make_instr(isa_pkg::C_STRIDED, 8'h04),
			alu, alu, 20, EV_NONE, 0, 0, 0, '0, '0);
		add_row("gather vector", 4'hf, 4'h5, alu, alu, gat, alu, 22, EV_NONE, 0, 0, 0, '0, '0);
		add_row("writeback hazard", 4'hf, 4'hf, fpu, alu, fpu, alu, 10, EV_NONE, 0, 0, 0,
			'0, '0);
		add_row("suspend resume", 4'hf, 4'h2, alu, make_instr(isa_pkg::C_STRIDED, 8'h04),
			alu, alu, 28, EV_SUSPEND, 1, 5, 12, '0, '0);
		add_row("rollback", 4'hf, 4'h5, alu, alu, gat, alu, 22, EV_ROLLBACK, 2, 6, 0,
			strand_pkg::lane_t'(7), 32'h100);
		add_row("retry", 4'hf, 4'h9, make_instr(isa_pkg::C_STRIDED, 8'h08), alu, alu, alu,
			24, EV_RETRY, 0, 4, 0, '0, '0);
	endtask

	task automatic reset_model(int r);
		for (int s = 0; s < NS; s++)
		begin
			m_st[s] = ST_WAIT;
			m_lane[s] = strand_pkg::lane_t'(strand_pkg::NUM_LANES - 1);
			m_off[s] = '0;
			pend[s] = row_load[r][s];
		end
		m_hist = '0;
		m_ptr = '0;
		e_instr = isa_pkg::NOP;
		e_pc = '0;
		e_bp = 1'b0;
		e_strand = '0;
		e_lane = '0;
		e_off = '0;
	endtask

	task automatic drive_cycle(int r, int c);
		rst_i <= 1'b0;
		for (int s = 0; s < NS; s++)
		begin
			valid[s] <= pend[s];
			susp[s] <= (row_kind[r] == EV_SUSPEND) && (row_ev_s[r] == s) && (row_ev_c[r] == c);
			res[s] <= (row_kind[r] == EV_SUSPEND) && (row_ev_s[r] == s) && (row_ev_c2[r] == c);
			rb[s] <= (row_kind[r] == EV_ROLLBACK) && (row_ev_s[r] == s) && (row_ev_c[r] == c);
			rt[s] <= (row_kind[r] == EV_RETRY) && (row_ev_s[r] == s) && (row_ev_c[r] == c);
		end
	endtask

	// Checks this cycle against the model, then advances the model by one clock
	task automatic run_cycle();
		strand_pkg::strand_mask_t req;
		strand_pkg::strand_mask_t exp_next;
		strand_pkg::strand_idx_t g;
		strand_pkg::strand_idx_t cand;
		logic found;
		logic last;
		logic mine;

		found = 1'b0;
		g = '0;
		for (int s = 0; s < NS; s++)
			req[s] = (m_st[s] == ST_READY) && en[s]
				&& !(m_hist[HAZ_DIST-1] && !long_class(instr[s]));
		for (int k = 0; k < NS; k++)
		begin
			cand = strand_pkg::strand_idx_t'((int'(m_ptr) + k) % NS);
			if (!found && req[cand])
			begin
				found = 1'b1;
				g = cand;
			end
		end
		last = !vector_class(instr[g]) || (m_lane[g] == '0);
		for (int s = 0; s < NS; s++)
			exp_next[s] = rb[s] || (found && (int'(g) == s) && last && !rt[s]);

		check_mask("next_instruction_o", next_instruction_o, exp_next);
		check_instr("ss_instruction_o", ss_instruction_o, e_instr);
		check_pc("ss_pc_o", ss_pc_o, e_pc);
		check_bit("ss_branch_predicted_o", ss_branch_predicted_o, e_bp);
		check_strand("ss_strand_o", ss_strand_o, e_strand);
		check_lane_offset(ss_lane_o, e_lane, ss_offset_o, e_off);

		if (found)
		begin
			e_instr = instr[g];
			e_pc = pc[g];
			e_bp = bp[g];
			e_strand = g;
			e_lane = m_lane[g];
			e_off = m_off[g];
		end
		else
		begin
			e_instr = isa_pkg::NOP;
			e_pc = '0;
			e_bp = 1'b0;
		end

		for (int s = 0; s < NS; s++)
		begin
			mine = found && (int'(g) == s);
			if ((m_st[s] == ST_WAIT) && valid[s] && !rb[s])
				pend[s] = 1'b0;
			if (rb[s])
			begin
				m_st[s] = ST_WAIT;
				m_lane[s] = rbl[s];
				m_off[s] = rbo[s];
				pend[s] = 1'b1;
			end
			else if (rt[s])
				m_st[s] = ST_READY;
			else
			begin
				if (mine && last)
				begin
					m_lane[s] = strand_pkg::lane_t'(strand_pkg::NUM_LANES - 1);
					m_off[s] = '0;
				end
				else if (mine)
				begin
					m_lane[s] = strand_pkg::lane_t'(m_lane[s] - 1);
					if (class_bits(instr[s]) == 4'h2)
						m_off[s] = m_off[s] + {24'h0, instr[s][7:0]};
				end
				if (susp[s])
					m_st[s] = ST_SUSP;
				else if ((m_st[s] == ST_WAIT) && valid[s])
					m_st[s] = ST_READY;
				else if ((m_st[s] == ST_READY) && mine && last)
					m_st[s] = ST_WAIT;
				else if ((m_st[s] == ST_SUSP) && res[s])
					m_st[s] = ST_READY;
			end
		end
		m_hist = {m_hist[HAZ_DIST-2:0], found && long_class(instr[g])};
		if (found)
			m_ptr = strand_pkg::strand_idx_t'((int'(g) + 1) % NS);
	endtask

	task automatic run_row(int r);
		logic [31:0] rnd;

		row_errors = 0;
		@(posedge clk);
		rst_i <= 1'b1;
		en <= row_en[r];
		for (int s = 0; s < NS; s++)
		begin
			rnd = $random(seed);
			instr[s] <= row_instr[r][s];
			pc[s] <= rnd;
			bp[s] <= rnd[0];
			valid[s] <= 1'b0;
			rbl[s] <= row_rb_lane[r];
			rbo[s] <= row_rb_off[r];
		end
		@(posedge clk);
		reset_model(r);
		for (int c = 0; c < row_len[r]; c++)
		begin
			drive_cycle(r, c);
			@(negedge clk);
			run_cycle();
			@(posedge clk);
		end
		if (row_errors == 0)
			$display("test %0d %s: ok", r, row_name[r]);
		else
		begin
			$display("test %0d %s: %0d errors", r, row_name[r], row_errors);
			failed_rows++;
		end
	endtask

	// Watchdog sized from the table, with room for the reset phases
	initial
	begin
		#((NUM_ROWS * (MAX_LEN + 4) + 16) * 8 + 400);
		$display("Watchdog expired before the test table completed");
		$display("Checks failed");
		$finish;
	end

	initial
	begin
		clk = 1'b0;
		rst_i = 1'b1;
		en = '0;
		seed = 97572;
		errors = 0;
		failed_rows = 0;
		for (int s = 0; s < NS; s++)
		begin
			instr[s] = isa_pkg::NOP;
			valid[s] = 1'b0;
			pc[s] = '0;
			bp[s] = 1'b0;
			rb[s] = 1'b0;
			rt[s] = 1'b0;
			susp[s] = 1'b0;
			res[s] = 1'b0;
			rbl[s] = '0;
			rbo[s] = '0;
		end
		build_table();
		repeat (16) @(posedge clk);
		for (int r = 0; r < n_rows; r++)
			run_row(r);
		$display("tests %0d, failing tests %0d, errors %0d", n_rows, failed_rows, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: tb.f
rtl/isa_pkg.sv
rtl/strand_pkg.sv
rtl/strand_fsm.sv
rtl/execute_hazard_detect.sv
rtl/issue_arbiter.sv
rtl/strand_select_stage.sv
tb/tb_strand_select.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_strand_select
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "Checks failed" $(LOG); then echo "Simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
